/* hw/ooo_cfg_pkg.sv */
`default_nettype none

package ooo_cfg_pkg;

  // reorder buffer sizing
  // tag width must cover rob_entries
  localparam int rob_tag_w = 2;
  localparam int rob_entries = 4;

  // datapath and architectural register file
  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int num_regs = 32;

  // width of the immediate field in an incoming instruction
  localparam int imm_w = 16;

endpackage

`default_nettype wire

/* hw/ooo_types_pkg.sv */
`default_nettype none

package ooo_types_pkg;

  import ooo_cfg_pkg::*;

  typedef enum logic [2:0] {
    op_add  = 3'd0,
    op_sub  = 3'd1,
    op_and  = 3'd2,
    op_or   = 3'd3,
    op_xor  = 3'd4,
    op_addi = 3'd5,
    op_li   = 3'd6
  } alu_op_e;

  // one instruction as it enters the back end
  typedef struct packed {
    alu_op_e               op;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] rs1;
    logic [reg_addr_w-1:0] rs2;
    logic [imm_w-1:0]      imm;
  } instr_t;

  // resolved operands handed to the ALU
  typedef struct packed {
    alu_op_e              op;
    logic [rob_tag_w-1:0] tag;
    logic [xlen-1:0]      a;
    logic [xlen-1:0]      b;
  } exec_req_t;

  typedef struct packed {
    logic [rob_tag_w-1:0] tag;
    logic [xlen-1:0]      value;
  } wb_t;

  // one retired instruction
  typedef struct packed {
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       value;
    logic [rob_tag_w-1:0]  tag;
  } commit_t;

endpackage

`default_nettype wire

/* hw/regfile_scoreboard.sv */
`default_nettype none

module regfile_scoreboard
  import ooo_cfg_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,

  // retirement write from the reorder buffer
  input  wire logic                  commit_we,
  input  wire logic [reg_addr_w-1:0] commit_rd,
  input  wire logic [xlen-1:0]       commit_value,
  input  wire logic [rob_tag_w-1:0]  commit_tag,

  // destination marking from dispatch
  input  wire logic                  issue_valid,
  input  wire logic [reg_addr_w-1:0] issue_rd,
  input  wire logic [rob_tag_w-1:0]  issue_tag,

  // source reads
  input  wire logic [reg_addr_w-1:0] rs1,
  input  wire logic [reg_addr_w-1:0] rs2,
  output logic      [xlen-1:0]       rs1_value,
  output logic      [xlen-1:0]       rs2_value,
  output logic                       rs1_ready,
  output logic                       rs2_ready,
  output logic      [rob_tag_w-1:0]  rs1_tag,
  output logic      [rob_tag_w-1:0]  rs2_tag
);

  logic [xlen-1:0]      regs_q [num_regs];
  logic                 busy_q [num_regs];
  logic [rob_tag_w-1:0] tag_q  [num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs_q[i] <= '0;
        busy_q[i] <= 1'b0;
        tag_q[i]  <= '0;
      end
    end else begin
      if (commit_we && (commit_rd != '0)) begin
        regs_q[commit_rd] <= commit_value;
        // rd stays busy when a younger producer renamed it meanwhile
        if (busy_q[commit_rd] && (tag_q[commit_rd] == commit_tag)) begin
          busy_q[commit_rd] <= 1'b0;
        end
      end

      // issue comes last so it overrides a clear from the same cycle
      if (issue_valid && (issue_rd != '0)) begin
        busy_q[issue_rd] <= 1'b1;
        tag_q[issue_rd]  <= issue_tag;
      end
    end
  end

  // x0 is hardwired to zero and never busy
  always_comb begin
    rs1_value = (rs1 == '0) ? '0 : regs_q[rs1];
    rs2_value = (rs2 == '0) ? '0 : regs_q[rs2];
    rs1_ready = (rs1 == '0) || !busy_q[rs1];
    rs2_ready = (rs2 == '0) || !busy_q[rs2];
    rs1_tag   = tag_q[rs1];
    rs2_tag   = tag_q[rs2];
  end

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`default_nettype none

module reorder_buffer
  import ooo_cfg_pkg::*;
  import ooo_types_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,

  // allocation at the tail
  input  wire logic                  alloc_valid,
  input  wire logic [reg_addr_w-1:0] alloc_rd,
  output logic                       alloc_ready,
  output logic      [rob_tag_w-1:0]  alloc_tag,

  // ALU writeback
  input  wire logic                  wb_valid,
  input  wire wb_t                   wb,

  // operand lookup for dispatch
  input  wire logic [rob_tag_w-1:0]  lookup_tag_a,
  input  wire logic [rob_tag_w-1:0]  lookup_tag_b,
  output logic                       lookup_done_a,
  output logic                       lookup_done_b,
  output logic      [xlen-1:0]       lookup_value_a,
  output logic      [xlen-1:0]       lookup_value_b,

  // in-order retirement
  output logic                       commit_we,
  output commit_t                    commit,
  input  wire logic                  commit_space
);

  logic [reg_addr_w-1:0] rd_q    [rob_entries];
  logic [xlen-1:0]       value_q [rob_entries];
  logic                  done_q  [rob_entries];

  logic [rob_tag_w-1:0] head_q;
  logic [rob_tag_w-1:0] tail_q;
  logic [rob_tag_w:0]   count_q;

  logic push;
  logic pop;
  logic bypass_a;
  logic bypass_b;

  assign alloc_ready = (count_q != (rob_tag_w + 1)'(rob_entries));
  assign alloc_tag   = tail_q;
  assign push        = alloc_valid && alloc_ready;

  // head leaves only when finished and the commit slice has room
  assign pop       = (count_q != '0) && done_q[head_q] && commit_space;
  assign commit_we = pop;
  assign commit    = '{rd: rd_q[head_q], value: value_q[head_q], tag: head_q};

  // same-cycle writeback is forwarded to the lookup
  assign bypass_a       = wb_valid && (wb.tag == lookup_tag_a);
  assign bypass_b       = wb_valid && (wb.tag == lookup_tag_b);
  assign lookup_done_a  = done_q[lookup_tag_a] || bypass_a;
  assign lookup_done_b  = done_q[lookup_tag_b] || bypass_b;
  assign lookup_value_a = bypass_a ? wb.value : value_q[lookup_tag_a];
  assign lookup_value_b = bypass_b ? wb.value : value_q[lookup_tag_b];

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int i = 0; i < rob_entries; i++) begin
        done_q[i] <= 1'b0;
      end
    end else begin
      if (push) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      if (wb_valid) begin
        done_q[wb.tag] <= 1'b1;
      end
      if (pop) begin
        head_q <= head_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // entry payload
  always_ff @(posedge clk) begin
    if (push) begin
      rd_q[tail_q] <= alloc_rd;
    end
    if (wb_valid) begin
      value_q[wb.tag] <= wb.value;
    end
  end

endmodule

`default_nettype wire

/* hw/dispatch_unit.sv */
`default_nettype none

module dispatch_unit
  import ooo_cfg_pkg::*;
  import ooo_types_pkg::*;
(
  input  wire logic                  clk,
  input  wire logic                  rst,

  input  wire logic                  instr_valid,
  input  wire instr_t                instr,
  output logic                       instr_ready,

  // scoreboard read and issue
  output logic      [reg_addr_w-1:0] rs1,
  output logic      [reg_addr_w-1:0] rs2,
  input  wire logic [xlen-1:0]       rs1_value,
  input  wire logic [xlen-1:0]       rs2_value,
  input  wire logic                  rs1_ready,
  input  wire logic                  rs2_ready,
  input  wire logic [rob_tag_w-1:0]  rs1_tag,
  input  wire logic [rob_tag_w-1:0]  rs2_tag,
  output logic                       issue_valid,
  output logic      [reg_addr_w-1:0] issue_rd,
  output logic      [rob_tag_w-1:0]  issue_tag,

  // reorder buffer alloc and lookup
  output logic                       alloc_valid,
  output logic      [reg_addr_w-1:0] alloc_rd,
  input  wire logic                  alloc_ready,
  input  wire logic [rob_tag_w-1:0]  alloc_tag,
  output logic      [rob_tag_w-1:0]  lookup_tag_a,
  output logic      [rob_tag_w-1:0]  lookup_tag_b,
  input  wire logic                  lookup_done_a,
  input  wire logic                  lookup_done_b,
  input  wire logic [xlen-1:0]       lookup_value_a,
  input  wire logic [xlen-1:0]       lookup_value_b,

  output logic                       exec_valid,
  output exec_req_t                  exec
);

  logic            live_q;
  logic            use_a;
  logic            use_b;
  logic            a_ok;
  logic            b_ok;
  logic            accept;
  logic [xlen-1:0] imm_ext;
  logic [xlen-1:0] val_a;
  logic [xlen-1:0] val_b;

  assign rs1          = instr.rs1;
  assign rs2          = instr.rs2;
  assign lookup_tag_a = rs1_tag;
  assign lookup_tag_b = rs2_tag;

  // li reads no source and addi reads only rs1
  assign use_a = (instr.op != op_li);
  assign use_b = (instr.op != op_li) && (instr.op != op_addi);

  assign a_ok = !use_a || rs1_ready || lookup_done_a;
  assign b_ok = !use_b || rs2_ready || lookup_done_b;

  assign imm_ext = {{(xlen - imm_w){instr.imm[imm_w-1]}}, instr.imm};
  assign val_a   = rs1_ready ? rs1_value : lookup_value_a;
  assign val_b   = use_b ? (rs2_ready ? rs2_value : lookup_value_b) : imm_ext;

  // stall on an unresolved source or a full buffer
  assign instr_ready = live_q && alloc_ready && a_ok && b_ok;
  assign accept      = instr_valid && instr_ready;

  assign alloc_valid = accept;
  assign alloc_rd    = instr.rd;
  assign issue_valid = accept;
  assign issue_rd    = instr.rd;
  assign issue_tag   = alloc_tag;

  always_ff @(posedge clk) begin
    if (rst) begin
      live_q     <= 1'b0;
      exec_valid <= 1'b0;
    end else begin
      live_q     <= 1'b1;
      exec_valid <= accept;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      exec <= '{op: instr.op, tag: alloc_tag, a: val_a, b: val_b};
    end
  end

endmodule

`default_nettype wire

/* hw/alu_unit.sv */
`default_nettype none

module alu_unit
  import ooo_cfg_pkg::*;
  import ooo_types_pkg::*;
(
  input  wire logic      clk,
  input  wire logic      rst,

  input  wire logic      exec_valid,
  input  wire exec_req_t exec,

  output logic           wb_valid,
  output wb_t            wb
);

  logic [xlen-1:0] result;

  always_comb begin
    case (exec.op)
      op_add, op_addi: result = exec.a + exec.b;
      op_sub:          result = exec.a - exec.b;
      op_and:          result = exec.a & exec.b;
      op_or:           result = exec.a | exec.b;
      op_xor:          result = exec.a ^ exec.b;
      // immediate already sits in operand b
      op_li:           result = exec.b;
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= exec_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (exec_valid) begin
      wb <= '{tag: exec.tag, value: result};
    end
  end

endmodule

`default_nettype wire

/* hw/skid_buffer.sv */
`default_nettype none

module skid_buffer #(
  parameter type payload_t = logic [31:0]
) (
  input  wire logic     clk,
  input  wire logic     rst,

  input  wire logic     in_valid,
  input  wire payload_t in_data,
  output logic          in_ready,

  output logic          out_valid,
  output payload_t      out_data,
  input  wire logic     out_ready
);

  payload_t   slot_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] fill_q;

  logic push;
  logic pop;

  // ready depends on the fill level alone
  assign in_ready  = (fill_q != 2'd2);
  assign out_valid = (fill_q != 2'd0);
  assign out_data  = slot_q[rd_ptr_q];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      fill_q   <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      case ({push, pop})
        2'b10:   fill_q <= fill_q + 1'b1;
        2'b01:   fill_q <= fill_q - 1'b1;
        default: fill_q <= fill_q;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      slot_q[wr_ptr_q] <= in_data;
    end
  end

endmodule

`default_nettype wire

/* hw/ooo_backend.sv */
`default_nettype none

module ooo_backend
  import ooo_cfg_pkg::*;
  import ooo_types_pkg::*;
(
  input  wire logic   clk,
  input  wire logic   rst,

  input  wire logic   instr_valid,
  input  wire instr_t instr,
  output logic        instr_ready,

  output logic        commit_valid,
  output commit_t     commit,
  input  wire logic   commit_ready
);

  // dispatch to scoreboard
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [xlen-1:0]       rs1_value;
  logic [xlen-1:0]       rs2_value;
  logic                  rs1_ready;
  logic                  rs2_ready;
  logic [rob_tag_w-1:0]  rs1_tag;
  logic [rob_tag_w-1:0]  rs2_tag;
  logic                  issue_valid;
  logic [reg_addr_w-1:0] issue_rd;
  logic [rob_tag_w-1:0]  issue_tag;

  // dispatch to reorder buffer
  logic                  alloc_valid;
  logic [reg_addr_w-1:0] alloc_rd;
  logic                  alloc_ready;
  logic [rob_tag_w-1:0]  alloc_tag;
  logic [rob_tag_w-1:0]  lookup_tag_a;
  logic [rob_tag_w-1:0]  lookup_tag_b;
  logic                  lookup_done_a;
  logic                  lookup_done_b;
  logic [xlen-1:0]       lookup_value_a;
  logic [xlen-1:0]       lookup_value_b;

  logic      exec_valid;
  exec_req_t exec;
  logic      wb_valid;
  wb_t       wb;

  // retirement path
  logic    rob_commit_we;
  commit_t rob_commit;
  logic    commit_space;

  dispatch_unit i_dispatch_unit (
    .clk            (clk),
    .rst            (rst),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .instr_ready    (instr_ready),
    .rs1            (rs1),
    .rs2            (rs2),
    .rs1_value      (rs1_value),
    .rs2_value      (rs2_value),
    .rs1_ready      (rs1_ready),
    .rs2_ready      (rs2_ready),
    .rs1_tag        (rs1_tag),
    .rs2_tag        (rs2_tag),
    .issue_valid    (issue_valid),
    .issue_rd       (issue_rd),
    .issue_tag      (issue_tag),
    .alloc_valid    (alloc_valid),
    .alloc_rd       (alloc_rd),
    .alloc_ready    (alloc_ready),
    .alloc_tag      (alloc_tag),
    .lookup_tag_a   (lookup_tag_a),
    .lookup_tag_b   (lookup_tag_b),
    .lookup_done_a  (lookup_done_a),
    .lookup_done_b  (lookup_done_b),
    .lookup_value_a (lookup_value_a),
    .lookup_value_b (lookup_value_b),
    .exec_valid     (exec_valid),
    .exec           (exec)
  );

  regfile_scoreboard i_regfile_scoreboard (
    .clk          (clk),
    .rst          (rst),
    .commit_we    (rob_commit_we),
    .commit_rd    (rob_commit.rd),
    .commit_value (rob_commit.value),
    .commit_tag   (rob_commit.tag),
    .issue_valid  (issue_valid),
    .issue_rd     (issue_rd),
    .issue_tag    (issue_tag),
    .rs1          (rs1),
    .rs2          (rs2),
    .rs1_value    (rs1_value),
    .rs2_value    (rs2_value),
    .rs1_ready    (rs1_ready),
    .rs2_ready    (rs2_ready),
    .rs1_tag      (rs1_tag),
    .rs2_tag      (rs2_tag)
  );

  reorder_buffer i_reorder_buffer (
    .clk            (clk),
    .rst            (rst),
    .alloc_valid    (alloc_valid),
    .alloc_rd       (alloc_rd),
    .alloc_ready    (alloc_ready),
    .alloc_tag      (alloc_tag),
    .wb_valid       (wb_valid),
    .wb             (wb),
    .lookup_tag_a   (lookup_tag_a),
    .lookup_tag_b   (lookup_tag_b),
    .lookup_done_a  (lookup_done_a),
    .lookup_done_b  (lookup_done_b),
    .lookup_value_a (lookup_value_a),
    .lookup_value_b (lookup_value_b),
    .commit_we      (rob_commit_we),
    .commit         (rob_commit),
    .commit_space   (commit_space)
  );

  alu_unit i_alu_unit (
    .clk        (clk),
    .rst        (rst),
    .exec_valid (exec_valid),
    .exec       (exec),
    .wb_valid   (wb_valid),
    .wb         (wb)
  );

  // output slice decouples the commit stream from the buffer head
  skid_buffer #(
    .payload_t (commit_t)
  ) i_commit_slice (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (rob_commit_we),
    .in_data   (rob_commit),
    .in_ready  (commit_space),
    .out_valid (commit_valid),
    .out_data  (commit),
    .out_ready (commit_ready)
  );

endmodule

`default_nettype wire

/* test/tb_ooo_backend.sv */
`default_nettype none

module tb_ooo_backend
  import ooo_cfg_pkg::*;
  import ooo_types_pkg::*;
();

  localparam int n_instr        = 20;
  localparam int timeout_cycles = 40 * n_instr + 100;
  localparam int hold_start     = 12;
  localparam int hold_len       = 30;

  logic    clk;
  logic    rst;
  logic    instr_valid;
  instr_t  instr;
  logic    instr_ready;
  logic    commit_valid;
  commit_t commit;
  logic    commit_ready;

  instr_t                prog      [n_instr];
  logic [reg_addr_w-1:0] exp_rd    [n_instr];
  logic [xlen-1:0]       exp_value [n_instr];

  int errors     = 0;
  int accept_cnt = 0;
  int commit_cnt = 0;
  int cycle_cnt  = 0;

  ooo_backend i_ooo_backend (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .instr_ready  (instr_ready),
    .commit_valid (commit_valid),
    .commit       (commit),
    .commit_ready (commit_ready)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  task automatic set_entry(input int idx, input alu_op_e op, input int rd, input int rs1,
                           input int rs2, input logic [imm_w-1:0] imm);
    prog[idx] = '{op: op, rd: reg_addr_w'(rd), rs1: reg_addr_w'(rs1),
                  rs2: reg_addr_w'(rs2), imm: imm};
  endtask

  // dependent chains, every opcode, x0 writes and reads
  task automatic build_table();
    set_entry(0,  op_li,   1,  0,  0,  16'h0005);
    set_entry(1,  op_li,   2,  0,  0,  16'hfffd);
    set_entry(2,  op_add,  3,  1,  2,  16'h0000);
    set_entry(3,  op_sub,  4,  3,  1,  16'h0000);
    set_entry(4,  op_and,  5,  4,  2,  16'h0000);
    set_entry(5,  op_or,   6,  5,  3,  16'h0000);
    set_entry(6,  op_xor,  7,  6,  4,  16'h0000);
    set_entry(7,  op_addi, 8,  7,  0,  16'h1234);
    set_entry(8,  op_li,   0,  0,  0,  16'h0077);
    set_entry(9,  op_add,  9,  0,  1,  16'h0000);
    set_entry(10, op_addi, 0,  9,  0,  16'h0001);
    set_entry(11, op_addi, 10, 0,  0,  16'h7fff);
    set_entry(12, op_li,   11, 0,  0,  16'h8000);
    set_entry(13, op_add,  11, 11, 11, 16'h0000);
    set_entry(14, op_sub,  12, 11, 10, 16'h0000);
    set_entry(15, op_xor,  13, 12, 12, 16'h0000);
    set_entry(16, op_or,   14, 13, 8,  16'h0000);
    set_entry(17, op_and,  15, 14, 11, 16'h0000);
    set_entry(18, op_addi, 1,  1,  0,  16'h0001);
    set_entry(19, op_add,  16, 1,  15, 16'h0000);
  endtask

  // in-order reference machine with x0 pinned to zero
  task automatic compute_expected();
    logic [xlen-1:0] arf [num_regs];
    logic [xlen-1:0] a;
    logic [xlen-1:0] b;
    logic [xlen-1:0] imm_ext;
    logic [xlen-1:0] res;
    for (int r = 0; r < num_regs; r++) begin
      arf[r] = '0;
    end
    for (int i = 0; i < n_instr; i++) begin
      a       = arf[prog[i].rs1];
      b       = arf[prog[i].rs2];
      imm_ext = xlen'($signed(prog[i].imm));
      case (prog[i].op)
        op_add:  res = a + b;
        op_sub:  res = a - b;
        op_and:  res = a & b;
        op_or:   res = a | b;
        op_xor:  res = a ^ b;
        op_addi: res = a + imm_ext;
        op_li:   res = imm_ext;
        default: res = 'x;
      endcase
      exp_rd[i]    = prog[i].rd;
      exp_value[i] = res;
      if (prog[i].rd != '0) begin
        arf[prog[i].rd] = res;
      end
    end
  endtask

  task automatic check_commit(input int idx, input commit_t c);
    assert (idx < n_instr) else begin
      errors++;
      $display("commit seen after all %0d table entries had retired", n_instr);
    end
    if (idx < n_instr) begin
      assert (c.rd == exp_rd[idx]) else begin
        errors++;
        $display("Mismatch at %0t: commit.rd (entry %0d) got %0d expected %0d",
                 $time, idx, c.rd, exp_rd[idx]);
      end
      assert (c.value == exp_value[idx]) else begin
        errors++;
        $display("Mismatch at %0t: commit.value (entry %0d) got %h expected %h",
                 $time, idx, c.value, exp_value[idx]);
      end
      assert (c.tag == rob_tag_w'(idx % rob_entries)) else begin
        errors++;
        $display("Mismatch at %0t: commit.tag (entry %0d) got %0d expected %0d",
                 $time, idx, c.tag, idx % rob_entries);
      end
    end
  endtask

  task automatic finish_run();
    $display("errors: %0d, accepted: %0d, committed: %0d of %0d",
             errors, accept_cnt, commit_cnt, n_instr);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  endtask

  // sampled at the falling edge away from the driving edge
  always @(negedge clk) begin
    if (rst) begin
      if (cycle_cnt > 0) begin
        assert (!instr_ready && !commit_valid) else begin
          errors++;
          $display("instr_ready or commit_valid high during reset");
        end
      end
    end else begin
      if (instr_valid && instr_ready) begin
        accept_cnt++;
      end
      if (commit_valid && commit_ready) begin
        check_commit(commit_cnt, commit);
        commit_cnt++;
      end
      assert (accept_cnt - commit_cnt <= rob_entries + 2) else begin
        errors++;
        $display("too many instructions in flight: %0d accepted, %0d committed",
                 accept_cnt, commit_cnt);
      end
    end
  end

  // random commit stalls with one long hold to fill the buffer
  initial begin
    void'($urandom(32'hd4844f43));
    @(negedge rst);
    forever begin
      @(posedge clk);
      #1;
      if (cycle_cnt >= hold_start && cycle_cnt < hold_start + hold_len) begin
        commit_ready = 1'b0;
      end else begin
        commit_ready = ($urandom % 4) != 0;
      end
    end
  end

  initial begin
    wait (cycle_cnt >= timeout_cycles);
    errors++;
    $display("timeout: run did not complete within %0d cycles", timeout_cycles);
    finish_run();
  end

  initial begin
    int  idx;
    logic taken;
    rst          = 1'b1;
    instr_valid  = 1'b0;
    instr        = '0;
    commit_ready = 1'b0;
    build_table();
    compute_expected();
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;

    // idle cycles before the first instruction
    repeat (3) begin
      @(negedge clk);
      assert (!commit_valid) else begin
        errors++;
        $display("commit_valid went high before any instruction was sent");
      end
    end
    @(posedge clk);
    #1;

    idx = 0;
    while (idx < n_instr) begin
      instr_valid = 1'b1;
      instr       = prog[idx];
      @(negedge clk);
      taken = instr_ready;
      @(posedge clk);
      #1;
      if (taken) begin
        idx++;
      end
    end
    instr_valid = 1'b0;
    instr       = '0;

    wait (commit_cnt == n_instr);
    // extra commits would show up here
    repeat (10) @(negedge clk);
    assert (accept_cnt == n_instr) else begin
      errors++;
      $display("accepted %0d instructions, table holds %0d", accept_cnt, n_instr);
    end
    finish_run();
  end

endmodule

`default_nettype wire

/* ooo_backend.f */
hw/ooo_cfg_pkg.sv
hw/ooo_types_pkg.sv
hw/regfile_scoreboard.sv
hw/reorder_buffer.sv
hw/dispatch_unit.sv
hw/alu_unit.sv
hw/skid_buffer.sv
hw/ooo_backend.sv
test/tb_ooo_backend.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ooo_backend
FILELIST  ?= ooo_backend.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= *** PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$($(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)
